// File: src/mips_isa_pkg.sv
package mips_isa_pkg;

    // ==========================================================
    // Field types
    // ==========================================================
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    localparam int NUM_REGS = 32;

    // Bit positions of the instruction fields.
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int SHAMT_LSB  = 6;

    // ==========================================================
    // Primary opcodes
    // ==========================================================
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_SLTIU = 6'h0b;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;

    // Function field values for SPECIAL.
    localparam funct_t F_SLL  = 6'h00;
    localparam funct_t F_SRL  = 6'h02;
    localparam funct_t F_SRA  = 6'h03;
    localparam funct_t F_SLLV = 6'h04;
    localparam funct_t F_SRLV = 6'h06;
    localparam funct_t F_SRAV = 6'h07;
    localparam funct_t F_ADD  = 6'h20;
    localparam funct_t F_ADDU = 6'h21;
    localparam funct_t F_SUB  = 6'h22;
    localparam funct_t F_SUBU = 6'h23;
    localparam funct_t F_AND  = 6'h24;
    localparam funct_t F_OR   = 6'h25;
    localparam funct_t F_XOR  = 6'h26;
    localparam funct_t F_NOR  = 6'h27;
    localparam funct_t F_SLT  = 6'h2a;
    localparam funct_t F_SLTU = 6'h2b;

endpackage

// File: src/core_ctl_pkg.sv
package core_ctl_pkg;

    // ==========================================================
    // Execute control
    // ==========================================================

    // Shift distance taken from shamt or the low bits of rs.
    typedef logic [4:0] shamt_t;

    // Add and subtract wrap, so the trapping forms share these codes.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_func_t;

    // Implicit destination of the link forms (JAL, JALR, BxxAL).
    // Those encodings are reserved here, and a reserved item carries
    // this index so it is never mistaken for an ordinary write.
    localparam mips_isa_pkg::reg_addr_t LINK_REG = 5'd31;

endpackage

// File: src/insn_decode.sv
module insn_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mips_isa_pkg::word_t       instr,
    input  logic                      valid,
    output mips_isa_pkg::reg_addr_t   rs_addr,
    output mips_isa_pkg::reg_addr_t   rt_addr,
    input  mips_isa_pkg::word_t       rs_data,
    input  mips_isa_pkg::word_t       rt_data,
    output logic                      ex_valid,
    output logic                      ex_illegal,
    output core_ctl_pkg::alu_func_t   ex_func,
    output mips_isa_pkg::word_t       ex_a,
    output mips_isa_pkg::word_t       ex_b,
    output mips_isa_pkg::reg_addr_t   ex_dest
);
    import mips_isa_pkg::*;
    import core_ctl_pkg::*;

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    shamt_t    shamt;
    imm_t      imm;
    word_t     imm_sext;
    word_t     imm_zext;

    alu_func_t dec_func;
    logic      dec_illegal;
    reg_addr_t dec_dest;
    word_t     dec_a;
    word_t     dec_b;

    assign opcode   = instr[OPCODE_LSB +: $bits(opcode_t)];
    assign rs       = instr[RS_LSB +: $bits(reg_addr_t)];
    assign rt       = instr[RT_LSB +: $bits(reg_addr_t)];
    assign rd       = instr[RD_LSB +: $bits(reg_addr_t)];
    assign shamt    = instr[SHAMT_LSB +: $bits(shamt_t)];
    assign funct    = instr[$bits(funct_t)-1:0];
    assign imm      = instr[$bits(imm_t)-1:0];
    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_zext = {16'h0000, imm};

    assign rs_addr = rs;
    assign rt_addr = rt;

    // ==========================================================
    // Opcode and function decode
    // ==========================================================
    always_comb begin
        dec_func    = ALU_ADD;
        dec_illegal = 1'b0;
        dec_dest    = rt;
        dec_a       = rs_data;
        dec_b       = imm_sext;
        case (opcode)
            OP_RTYPE: begin
                dec_dest = rd;
                dec_b    = rt_data;
                case (funct)
                    F_ADD, F_ADDU: dec_func = ALU_ADD;
                    F_SUB, F_SUBU: dec_func = ALU_SUB;
                    F_AND:         dec_func = ALU_AND;
                    F_OR:          dec_func = ALU_OR;
                    F_XOR:         dec_func = ALU_XOR;
                    F_NOR:         dec_func = ALU_NOR;
                    F_SLT:         dec_func = ALU_SLT;
                    F_SLTU:        dec_func = ALU_SLTU;
                    F_SLLV:        dec_func = ALU_SLL;
                    F_SRLV:        dec_func = ALU_SRL;
                    F_SRAV:        dec_func = ALU_SRA;
                    F_SLL, F_SRL, F_SRA: begin
                        // Fixed shifts take the distance from shamt.
                        dec_a = word_t'(shamt);
                        if (funct == F_SLL) begin
                            dec_func = ALU_SLL;
                        end else if (funct == F_SRL) begin
                            dec_func = ALU_SRL;
                        end else begin
                            dec_func = ALU_SRA;
                        end
                    end
                    default: begin
                        dec_illegal = 1'b1;
                        dec_dest    = LINK_REG;
                    end
                endcase
            end
            OP_ADDI, OP_ADDIU: dec_func = ALU_ADD;
            OP_SLTI:           dec_func = ALU_SLT;
            OP_SLTIU:          dec_func = ALU_SLTU;
            OP_LUI:            dec_func = ALU_LUI;
            OP_ANDI, OP_ORI, OP_XORI: begin
                dec_b = imm_zext;
                if (opcode == OP_ANDI) begin
                    dec_func = ALU_AND;
                end else if (opcode == OP_ORI) begin
                    dec_func = ALU_OR;
                end else begin
                    dec_func = ALU_XOR;
                end
            end
            default: begin
                dec_illegal = 1'b1;
                dec_dest    = LINK_REG;
            end
        endcase
    end

    // Decode to execute stage.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid   <= 1'b0;
            ex_illegal <= 1'b0;
        end else begin
            ex_valid   <= valid;
            ex_illegal <= valid & dec_illegal;
        end
    end

    always_ff @(posedge clk) begin
        ex_func <= dec_func;
        ex_a    <= dec_a;
        ex_b    <= dec_b;
        ex_dest <= dec_dest;
    end

    a_instr_known: assert property (
        @(posedge clk) disable iff (!rst_n) valid |-> !$isunknown(instr)
    );

endmodule

// File: src/alu_execute.sv
module alu_execute (
    input  logic                      ex_valid,
    input  logic                      ex_illegal,
    input  core_ctl_pkg::alu_func_t   ex_func,
    input  mips_isa_pkg::word_t       ex_a,
    input  mips_isa_pkg::word_t       ex_b,
    input  mips_isa_pkg::reg_addr_t   ex_dest,
    output logic                      res_valid,
    output logic                      res_illegal,
    output mips_isa_pkg::reg_addr_t   res_dest,
    output mips_isa_pkg::word_t       res_data
);
    import mips_isa_pkg::*;
    import core_ctl_pkg::*;

    shamt_t sa;
    logic   lt_signed;
    logic   lt_unsigned;

    // Only the low five bits of the distance count.
    assign sa = ex_a[$bits(shamt_t)-1:0];

    assign lt_signed   = $signed(ex_a) < $signed(ex_b);
    assign lt_unsigned = ex_a < ex_b;

    // ==========================================================
    // Result select
    // ==========================================================
    always_comb begin
        case (ex_func)
            ALU_ADD:  res_data = ex_a + ex_b;
            ALU_SUB:  res_data = ex_a - ex_b;
            ALU_AND:  res_data = ex_a & ex_b;
            ALU_OR:   res_data = ex_a | ex_b;
            ALU_XOR:  res_data = ex_a ^ ex_b;
            ALU_NOR:  res_data = ~(ex_a | ex_b);
            ALU_SLT:  res_data = {31'b0, lt_signed};
            ALU_SLTU: res_data = {31'b0, lt_unsigned};
            ALU_SLL:  res_data = ex_b << sa;
            ALU_SRL:  res_data = ex_b >> sa;
            ALU_SRA:  res_data = $signed(ex_b) >>> sa;
            ALU_LUI:  res_data = {ex_b[$bits(imm_t)-1:0], 16'h0000};
            default:  res_data = '0;
        endcase
    end

    // A reserved item never reaches the register file.
    assign res_valid   = ex_valid & ~ex_illegal;
    assign res_illegal = ex_illegal;
    assign res_dest    = ex_dest;

endmodule

// File: src/writeback_result.sv
module writeback_result (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      res_valid,
    input  logic                      res_illegal,
    input  mips_isa_pkg::reg_addr_t   res_dest,
    input  mips_isa_pkg::word_t       res_data,
    input  mips_isa_pkg::reg_addr_t   rs_addr,
    input  mips_isa_pkg::reg_addr_t   rt_addr,
    output mips_isa_pkg::word_t       rs_data,
    output mips_isa_pkg::word_t       rt_data,
    output logic                      wb_valid,
    output logic                      illegal,
    output mips_isa_pkg::reg_addr_t   wb_reg,
    output mips_isa_pkg::word_t       wb_data
);
    import mips_isa_pkg::*;

    word_t regs [NUM_REGS];

    // r0 reads zero; a write at this edge is forwarded.
    function automatic word_t read_port(reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (res_valid && res_dest == addr) begin
            value = res_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    // ==========================================================
    // Register file and writeback registers
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (res_valid && res_dest != '0) begin
            regs[res_dest] <= res_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            wb_valid <= res_valid;
            illegal  <= res_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            wb_reg  <= res_dest;
            wb_data <= res_data;
        end
    end

    a_wb_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(wb_valid && illegal)
    );

endmodule

// File: src/mips_alu_core.sv
module mips_alu_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mips_isa_pkg::word_t       instr,
    input  logic                      valid,
    output logic                      wb_valid,
    output mips_isa_pkg::reg_addr_t   wb_reg,
    output mips_isa_pkg::word_t       wb_data,
    output logic                      illegal
);
    import mips_isa_pkg::*;
    import core_ctl_pkg::*;

    // Register file read ports.
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    // Decode to execute stage.
    logic      ex_valid;
    logic      ex_illegal;
    alu_func_t ex_func;
    word_t     ex_a;
    word_t     ex_b;
    reg_addr_t ex_dest;

    // Execute result.
    logic      res_valid;
    logic      res_illegal;
    reg_addr_t res_dest;
    word_t     res_data;

    insn_decode decode_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .valid      (valid),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .ex_valid   (ex_valid),
        .ex_illegal (ex_illegal),
        .ex_func    (ex_func),
        .ex_a       (ex_a),
        .ex_b       (ex_b),
        .ex_dest    (ex_dest)
    );

    alu_execute execute_i (
        .ex_valid    (ex_valid),
        .ex_illegal  (ex_illegal),
        .ex_func     (ex_func),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_dest     (ex_dest),
        .res_valid   (res_valid),
        .res_illegal (res_illegal),
        .res_dest    (res_dest),
        .res_data    (res_data)
    );

    writeback_result writeback_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .res_valid   (res_valid),
        .res_illegal (res_illegal),
        .res_dest    (res_dest),
        .res_data    (res_data),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .wb_valid    (wb_valid),
        .illegal     (illegal),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data)
    );

endmodule

// File: sim/wb_checker.sv
module wb_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    exp_strobe,
    input  logic [95:0]             exp_name,
    input  logic                    exp_illegal,
    input  mips_isa_pkg::reg_addr_t exp_reg,
    input  mips_isa_pkg::word_t     exp_data,
    input  logic                    wb_valid,
    input  mips_isa_pkg::reg_addr_t wb_reg,
    input  mips_isa_pkg::word_t     wb_data,
    input  logic                    illegal,
    output int                      done_count,
    output int                      error_count
);
    import mips_isa_pkg::*;

    // Expectations in issue order.
    logic [95:0] name_q [$];
    logic        ill_q  [$];
    reg_addr_t   reg_q  [$];
    word_t       data_q [$];

    logic [95:0] head_name;
    logic        head_ill;
    reg_addr_t   head_reg;
    word_t       head_data;

    always @(posedge clk) begin
        if (!rst_n) begin
            name_q.delete();
            ill_q.delete();
            reg_q.delete();
            data_q.delete();
            done_count  = 0;
            error_count = 0;
        end else begin
            if (exp_strobe) begin
                name_q.push_back(exp_name);
                ill_q.push_back(exp_illegal);
                reg_q.push_back(exp_reg);
                data_q.push_back(exp_data);
            end
            if (wb_valid || illegal) begin
                if (name_q.size() == 0) begin
                    $display("ERROR: no test pending at writeback (wb_valid=%0b illegal=%0b)",
                             wb_valid, illegal);
                    error_count++;
                end else begin
                    head_name = name_q.pop_front();
                    head_ill  = ill_q.pop_front();
                    head_reg  = reg_q.pop_front();
                    head_data = data_q.pop_front();
                    done_count++;
                    if (head_ill) begin
                        if (illegal && !wb_valid) begin
                            $display("PASS %0s: illegal pulse", head_name);
                        end else begin
                            $display("MISMATCH %0s: expected illegal pulse, actual r%0d = %h",
                                     head_name, wb_reg, wb_data);
                            error_count++;
                        end
                    end else if (!wb_valid || illegal) begin
                        $display("MISMATCH %0s: expected r%0d = %h, actual illegal pulse",
                                 head_name, head_reg, head_data);
                        error_count++;
                    end else if (wb_reg !== head_reg || wb_data !== head_data) begin
                        $display("MISMATCH %0s: expected r%0d = %h, actual r%0d = %h",
                                 head_name, head_reg, head_data, wb_reg, wb_data);
                        error_count++;
                    end else begin
                        $display("PASS %0s: r%0d = %h", head_name, wb_reg, wb_data);
                    end
                end
            end
        end
    end

endmodule

// File: sim/mips_alu_core_tb.sv
module mips_alu_core_tb;
    import mips_isa_pkg::*;

    localparam int MAX_TESTS  = 40;
    localparam int WAIT_LIMIT = 100;

    typedef struct packed {
        logic [95:0] name;
        word_t       instr;
        logic        ill;
        reg_addr_t   rd;
        word_t       data;
        logic        b2b;
    } test_t;

    logic        clk;
    logic        rst_n;
    word_t       instr;
    logic        valid;
    logic        wb_valid;
    reg_addr_t   wb_reg;
    word_t       wb_data;
    logic        illegal;

    logic        exp_strobe;
    logic [95:0] exp_name;
    logic        exp_illegal;
    reg_addr_t   exp_reg;
    word_t       exp_data;
    int          done_count;
    int          error_count;

    test_t       tests [MAX_TESTS];
    int          num_tests;
    logic [31:0] rng;
    int          gap;
    int          waited;
    logic        timed_out;

    mips_alu_core dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .valid    (valid),
        .wb_valid (wb_valid),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .illegal  (illegal)
    );

    wb_checker chk_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .exp_strobe  (exp_strobe),
        .exp_name    (exp_name),
        .exp_illegal (exp_illegal),
        .exp_reg     (exp_reg),
        .exp_data    (exp_data),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .illegal     (illegal),
        .done_count  (done_count),
        .error_count (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic word_t r_insn(funct_t f, int rs, int rt, int rd, int sh);
        word_t w;
        w = '0;
        w[OPCODE_LSB +: 6] = OP_RTYPE;
        w[RS_LSB +: 5]     = reg_addr_t'(rs);
        w[RT_LSB +: 5]     = reg_addr_t'(rt);
        w[RD_LSB +: 5]     = reg_addr_t'(rd);
        w[SHAMT_LSB +: 5]  = 5'(sh);
        w[5:0]             = f;
        return w;
    endfunction

    function automatic word_t i_insn(opcode_t op, int rs, int rt, imm_t imm);
        word_t w;
        w = '0;
        w[OPCODE_LSB +: 6] = op;
        w[RS_LSB +: 5]     = reg_addr_t'(rs);
        w[RT_LSB +: 5]     = reg_addr_t'(rt);
        w[15:0]            = imm;
        return w;
    endfunction

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_test(input logic [95:0] name, input word_t word, input int ill,
                            input int rd, input word_t data, input int b2b);
        tests[num_tests] = {name, word, ill != 0, reg_addr_t'(rd), data, b2b != 0};
        num_tests++;
    endtask

    // ============================================================
    // Stimulus table
    // ============================================================
    task automatic load_table();
        add_test("addu_zero", r_insn(F_ADDU, 1, 2, 3, 0), 0, 3, 32'h0000_0000, 0);
        add_test("addiu_neg", i_insn(OP_ADDIU, 0, 1, 16'hffff), 0, 1, 32'hffff_ffff, 0);
        add_test("addi_pos", i_insn(OP_ADDI, 0, 2, 16'h7fff), 0, 2, 32'h0000_7fff, 0);
        add_test("addi_neg", i_insn(OP_ADDI, 2, 3, 16'hfffe), 0, 3, 32'h0000_7ffd, 0);
        add_test("lui_sign", i_insn(OP_LUI, 0, 4, 16'h8000), 0, 4, 32'h8000_0000, 0);
        add_test("ori", i_insn(OP_ORI, 4, 5, 16'h1234), 0, 5, 32'h8000_1234, 0);
        add_test("andi", i_insn(OP_ANDI, 1, 6, 16'hf0f0), 0, 6, 32'h0000_f0f0, 0);
        add_test("xori", i_insn(OP_XORI, 1, 7, 16'h00ff), 0, 7, 32'hffff_ff00, 0);
        add_test("slti", i_insn(OP_SLTI, 1, 8, 16'h0000), 0, 8, 32'h0000_0001, 0);
        add_test("sltiu", i_insn(OP_SLTIU, 2, 9, 16'h8000), 0, 9, 32'h0000_0001, 0);
        add_test("lui_pos", i_insn(OP_LUI, 0, 10, 16'h7fff), 0, 10, 32'h7fff_0000, 0);
        add_test("add_wrap", r_insn(F_ADD, 10, 10, 11, 0), 0, 11, 32'hfffe_0000, 0);
        add_test("addu_wrap", r_insn(F_ADDU, 1, 8, 12, 0), 0, 12, 32'h0000_0000, 0);
        add_test("sub_wrap", r_insn(F_SUB, 4, 8, 13, 0), 0, 13, 32'h7fff_ffff, 0);
        add_test("subu", r_insn(F_SUBU, 0, 8, 14, 0), 0, 14, 32'hffff_ffff, 0);
        add_test("and", r_insn(F_AND, 5, 7, 15, 0), 0, 15, 32'h8000_1200, 0);
        add_test("or", r_insn(F_OR, 2, 10, 16, 0), 0, 16, 32'h7fff_7fff, 0);
        add_test("xor", r_insn(F_XOR, 5, 1, 17, 0), 0, 17, 32'h7fff_edcb, 0);
        add_test("nor", r_insn(F_NOR, 6, 2, 18, 0), 0, 18, 32'hffff_0000, 0);
        add_test("slt", r_insn(F_SLT, 4, 2, 19, 0), 0, 19, 32'h0000_0001, 0);
        add_test("sltu", r_insn(F_SLTU, 4, 2, 20, 0), 0, 20, 32'h0000_0000, 0);
        add_test("sll", r_insn(F_SLL, 0, 5, 21, 4), 0, 21, 32'h0001_2340, 0);
        add_test("srl", r_insn(F_SRL, 0, 4, 22, 8), 0, 22, 32'h0080_0000, 0);
        add_test("sra", r_insn(F_SRA, 0, 4, 23, 8), 0, 23, 32'hff80_0000, 0);
        // Only the low five bits of the distance 0x24 count.
        add_test("shift_amt", i_insn(OP_ADDIU, 0, 25, 16'h0024), 0, 25, 32'h0000_0024, 0);
        add_test("sllv", r_insn(F_SLLV, 25, 2, 26, 0), 0, 26, 32'h0007_fff0, 0);
        add_test("srlv", r_insn(F_SRLV, 25, 4, 27, 0), 0, 27, 32'h0800_0000, 0);
        add_test("srav", r_insn(F_SRAV, 25, 7, 28, 0), 0, 28, 32'hffff_fff0, 0);
        add_test("chain_a", i_insn(OP_ADDIU, 0, 29, 16'h0005), 0, 29, 32'h0000_0005, 0);
        add_test("chain_b", r_insn(F_ADDU, 29, 29, 29, 0), 0, 29, 32'h0000_000a, 1);
        add_test("chain_c", r_insn(F_SLL, 0, 29, 30, 2), 0, 30, 32'h0000_0028, 1);
        add_test("write_r0", i_insn(OP_ADDIU, 1, 0, 16'h0003), 0, 0, 32'h0000_0002, 0);
        add_test("read_r0", r_insn(F_ADDU, 0, 0, 31, 0), 0, 31, 32'h0000_0000, 1);
        // A load opcode and an unknown function field.
        add_test("lw_illegal", i_insn(6'h23, 0, 29, 16'h0004), 1, 0, 32'h0000_0000, 0);
        add_test("bad_funct", r_insn(6'h3f, 29, 29, 29, 0), 1, 0, 32'h0000_0000, 0);
        add_test("r29_kept", r_insn(F_OR, 29, 0, 24, 0), 0, 24, 32'h0000_000a, 1);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        rst_n       = 1'b0;
        instr       = '0;
        valid       = 1'b0;
        exp_strobe  = 1'b0;
        exp_name    = '0;
        exp_illegal = 1'b0;
        exp_reg     = '0;
        exp_data    = '0;
        num_tests   = 0;
        rng         = 32'h85ee2170;
        timed_out   = 1'b0;
        load_table();

        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        // Idle cycles with valid low. The checker flags any stray pulse.
        repeat (3) @(posedge clk);

        for (int i = 0; i < num_tests; i++) begin
            gap = 0;
            if (i > 0 && !tests[i].b2b) begin
                rng = xorshift32(rng);
                gap = int'(rng % 3);
            end
            repeat (gap) begin
                @(posedge clk);
                #1;
                valid      = 1'b0;
                exp_strobe = 1'b0;
            end
            @(posedge clk);
            #1;
            instr       = tests[i].instr;
            valid       = 1'b1;
            exp_strobe  = 1'b1;
            exp_name    = tests[i].name;
            exp_illegal = tests[i].ill;
            exp_reg     = tests[i].rd;
            exp_data    = tests[i].data;
        end
        @(posedge clk);
        #1;
        valid      = 1'b0;
        exp_strobe = 1'b0;

        waited = 0;
        while (done_count < num_tests && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (done_count < num_tests) begin
            $display("timeout: only %0d of %0d tests reached writeback", done_count, num_tests);
            timed_out = 1'b1;
        end

        repeat (4) @(posedge clk);
        #1;
        $display("tests: %0d  completed: %0d  errors: %0d", num_tests, done_count, error_count);
        if (!timed_out && error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: mips_alu_core.f
src/mips_isa_pkg.sv
src/core_ctl_pkg.sv
src/insn_decode.sv
src/alu_execute.sv
src/writeback_result.sv
src/mips_alu_core.sv
sim/wb_checker.sv
sim/mips_alu_core_tb.sv
